//--- bench/gpu_dispatch_tb.sv
// ****************************************
// GPU dispatch testbench
// Table of workgroups, CU done model and
// reference slot occupancy
// ****************************************
`timescale 1ns/1ps
`include "gpu_dispatch_cfg.svh"

module gpu_dispatch_tb
  import gpu_dispatch_pkg::*;
;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_ROWS   = 10;

  logic                 clk;
  logic                 rst_n;
  logic                 alloc_valid_i;
  wg_id_t               alloc_wg_id_i;
  cu_id_t               alloc_cu_id_i;
  wf_cnt_t              alloc_wf_count_i;
  vgpr_t                alloc_vgpr_start_i;
  sgpr_t                alloc_sgpr_start_i;
  vgpr_t                alloc_vgpr_size_i;
  sgpr_t                alloc_sgpr_size_i;
  logic                 alloc_available_o;
  logic [`NUM_CU-1:0]   wf_dispatch_o;
  tag_t                 wf_tag_o;
  wf_cnt_t              wf_count_o;
  vgpr_t                wf_vgpr_base_o;
  sgpr_t                wf_sgpr_base_o;
  logic [`NUM_CU-1:0]   wf_done_i;
  tag_t [`NUM_CU-1:0]   wf_done_tag_i;
  logic                 dealloc_valid_o;
  cu_id_t               dealloc_cu_id_o;
  wg_id_t               dealloc_wg_id_o;
  logic                 dealloc_ack_i;

  // Workgroup table
  // Nibble j of perm is the wavefront that finishes j-th
  int row_cu     [NUM_ROWS] = '{0, 2, 2, 1, 3, 0, 2, 2, 2, 2};
  int row_wg     [NUM_ROWS] = '{'h11, 'h22, 'h23, 'h34, 'h45, 'h56, 'h67, 'h68, 'h69, 'h6a};
  int row_cnt    [NUM_ROWS] = '{3, 8, 1, 4, 2, 5, 2, 3, 1, 6};
  int row_vstart [NUM_ROWS] = '{'h010, 'h3f0, 'h000, 'h100, 'h200,
                                'h050, 'h120, 'h2a0, 'h0ff, 'h3ff};
  int row_vsize  [NUM_ROWS] = '{4, 'h20, 0, 8, 'h40, 'h10, 2, 'h33, 1, 'h81};
  int row_sstart [NUM_ROWS] = '{8, 'hf0, 'h10, 'h20, 'h30, 'h40, 'h80, 'h90, 'ha0, 'hfe};
  int row_ssize  [NUM_ROWS] = '{2, 5, 1, 4, 8, 3, 'h11, 6, 0, 'h7f};
  int row_perm   [NUM_ROWS] = '{'h102, 'h01234567, 0, 'h2013, 'h01,
                                'h43210, 'h10, 'h021, 0, 'h321045};
  // Rows that close a batch and complete every pending workgroup
  bit row_last   [NUM_ROWS] = '{1, 0, 0, 0, 0, 1, 0, 0, 0, 1};

  integer               seed;
  logic [`WG_SLOTS-1:0] slot_busy [`NUM_CU];
  int                   pend_row  [$];
  int                   pend_slot [$];
  tag_t                 done_fifo [`NUM_CU][$];

  gpu_dispatch_top gpu_dispatch_top_inst (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_val(string name, int exp, int act);
    assert (exp == act) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
      report_failure("value check failed");
    end
  endtask

  function automatic int lowest_free(int cu);
    for (int s = 0; s < `WG_SLOTS; s++) begin
      if (!slot_busy[cu][s]) return s;
    end
    return -1;
  endfunction

  function automatic int perm_at(int r, int j);
    return (row_perm[r] >> (4 * j)) & 7;
  endfunction

  task automatic alloc_row(int r);
    int slot;
    int exp_v;
    int exp_s;
    slot = lowest_free(row_cu[r]);
    assert (slot >= 0) else report_failure("table puts too many workgroups on one CU");
    while (!alloc_available_o) step();
    alloc_valid_i      = 1'b1;
    alloc_cu_id_i      = cu_id_t'(row_cu[r]);
    alloc_wg_id_i      = wg_id_t'(row_wg[r]);
    alloc_wf_count_i   = wf_cnt_t'(row_cnt[r]);
    alloc_vgpr_start_i = vgpr_t'(row_vstart[r]);
    alloc_vgpr_size_i  = vgpr_t'(row_vsize[r]);
    alloc_sgpr_start_i = sgpr_t'(row_sstart[r]);
    alloc_sgpr_size_i  = sgpr_t'(row_ssize[r]);
    step();
    alloc_valid_i = 1'b0;
    check_val($sformatf("row%0d available after accept", r), 0, alloc_available_o);
    check_val($sformatf("row%0d no early dispatch", r), 0, wf_dispatch_o);
    step();
    for (int k = 0; k < row_cnt[r]; k++) begin
      exp_v = (row_vstart[r] + k * row_vsize[r]) & ((1 << `VGPR_W) - 1);
      exp_s = (row_sstart[r] + k * row_ssize[r]) & ((1 << `SGPR_W) - 1);
      check_val($sformatf("row%0d wf%0d dispatch", r, k), 1 << row_cu[r], wf_dispatch_o);
      check_val($sformatf("row%0d wf%0d tag", r, k), (slot << `WF_IDX_W) | k, wf_tag_o);
      check_val($sformatf("row%0d wf%0d count", r, k), row_cnt[r], wf_count_o);
      check_val($sformatf("row%0d wf%0d vgpr", r, k), exp_v, wf_vgpr_base_o);
      check_val($sformatf("row%0d wf%0d sgpr", r, k), exp_s, wf_sgpr_base_o);
      check_val($sformatf("row%0d wf%0d available", r, k), 0, alloc_available_o);
      step();
    end
    check_val($sformatf("row%0d dispatch end", r), 0, wf_dispatch_o);
    check_val($sformatf("row%0d available again", r), 1, alloc_available_o);
    slot_busy[row_cu[r]][slot] = 1'b1;
    pend_row.push_back(r);
    pend_slot.push_back(slot);
  endtask

  // All but the last done of each workgroup with random gaps
  task automatic send_early_dones();
    bit busy;
    for (int p = 0; p < pend_row.size(); p++) begin
      for (int j = 0; j < row_cnt[pend_row[p]] - 1; j++) begin
        done_fifo[row_cu[pend_row[p]]].push_back(
          tag_t'((pend_slot[p] << `WF_IDX_W) | perm_at(pend_row[p], j)));
      end
    end
    busy = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int c = 0; c < `NUM_CU; c++) begin
        wf_done_i[c] = 1'b0;
        if (done_fifo[c].size() > 0 && ($random(seed) & 1)) begin
          wf_done_i[c]     = 1'b1;
          wf_done_tag_i[c] = done_fifo[c].pop_front();
        end
        if (done_fifo[c].size() > 0 || wf_done_i[c]) busy = 1'b1;
      end
      step();
      assert (!dealloc_valid_o)
        else report_failure("dealloc raised before all wavefronts of a workgroup finished");
    end
    wf_done_i = '0;
    // Completion takes a few cycles to reach the dealloc port
    repeat (4) begin
      step();
      assert (!dealloc_valid_o)
        else report_failure("dealloc raised before all wavefronts of a workgroup finished");
    end
  endtask

  // Last dones in rounds by slot rank
  // Rank 0 of every CU lands in the same cycle
  task automatic send_last_dones();
    int rank;
    int r;
    for (int round = 0; round < `WG_SLOTS; round++) begin
      wf_done_i = '0;
      for (int p = 0; p < pend_row.size(); p++) begin
        r    = pend_row[p];
        rank = 0;
        for (int q = 0; q < pend_row.size(); q++) begin
          if (row_cu[pend_row[q]] == row_cu[r] && pend_slot[q] < pend_slot[p]) rank++;
        end
        if (rank == round) begin
          wf_done_i[row_cu[r]]     = 1'b1;
          wf_done_tag_i[row_cu[r]] =
            tag_t'((pend_slot[p] << `WF_IDX_W) | perm_at(r, row_cnt[r] - 1));
        end
      end
      step();
    end
    wf_done_i = '0;
  endtask

  // Expect deallocs in ascending CU and slot order
  task automatic drain_deallocs();
    int r;
    repeat (8) step();
    for (int key = 0; key < `NUM_CU * `WG_SLOTS; key++) begin
      for (int p = 0; p < pend_row.size(); p++) begin
        r = pend_row[p];
        if (row_cu[r] * `WG_SLOTS + pend_slot[p] == key) begin
          while (!dealloc_valid_o) step();
          repeat (2) begin
            check_val($sformatf("row%0d dealloc cu", r), row_cu[r], dealloc_cu_id_o);
            check_val($sformatf("row%0d dealloc wg", r), row_wg[r], dealloc_wg_id_o);
            check_val($sformatf("row%0d dealloc held", r), 1, dealloc_valid_o);
            step();
          end
          dealloc_ack_i = 1'b1;
          step();
          dealloc_ack_i = 1'b0;
          slot_busy[row_cu[r]][pend_slot[p]] = 1'b0;
          while (dealloc_valid_o) step();
        end
      end
    end
    repeat (10) begin
      step();
      assert (!dealloc_valid_o) else report_failure("extra dealloc after all were acked");
    end
    pend_row.delete();
    pend_slot.delete();
  endtask

  initial begin
    seed               = 32'h50b8a67a;
    clk                = 1'b0;
    rst_n              = 1'b0;
    alloc_valid_i      = 1'b0;
    alloc_wg_id_i      = '0;
    alloc_cu_id_i      = '0;
    alloc_wf_count_i   = '0;
    alloc_vgpr_start_i = '0;
    alloc_sgpr_start_i = '0;
    alloc_vgpr_size_i  = '0;
    alloc_sgpr_size_i  = '0;
    wf_done_i          = '0;
    wf_done_tag_i      = '0;
    dealloc_ack_i      = 1'b0;
    for (int c = 0; c < `NUM_CU; c++) slot_busy[c] = '0;
    repeat (3) begin
      step();
      check_val("reset dispatch", 0, wf_dispatch_o);
      check_val("reset dealloc", 0, dealloc_valid_o);
      check_val("reset available", 0, alloc_available_o);
    end
    rst_n = 1'b1;
    step();
    check_val("available after reset", 1, alloc_available_o);
    check_val("dispatch after reset", 0, wf_dispatch_o);
    check_val("dealloc after reset", 0, dealloc_valid_o);
    for (int r = 0; r < NUM_ROWS; r++) begin
      alloc_row(r);
      if (row_last[r]) begin
        send_early_dones();
        send_last_dones();
        drain_deallocs();
      end
    end
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_ROWS * 64 * CLK_PERIOD);
    report_failure("timeout: run did not complete in time");
  end

endmodule

//--- design/cu_handler.sv
// ****************************************
// CU workgroup handler
// Slot table of workgroups in flight on one
// CU, counts wavefront completions
// ****************************************
`timescale 1ns/1ps
`include "gpu_dispatch_cfg.svh"

module cu_handler
  import gpu_dispatch_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    alloc_en_i,
  input  wg_id_t  alloc_wg_id_i,
  input  wf_cnt_t alloc_wf_count_i,
  input  logic    wf_done_i,
  input  tag_t    wf_done_tag_i,
  input  logic    done_ack_i,
  output slot_t   free_slot_o,
  output logic    wg_done_o,
  output wg_id_t  wg_done_id_o
);

  logic [`WG_SLOTS-1:0] busy_q;
  logic [`WG_SLOTS-1:0] finished;
  wg_id_t               wg_id_q    [`WG_SLOTS];
  wf_cnt_t              wf_cnt_q   [`WG_SLOTS];
  wf_cnt_t              done_cnt_q [`WG_SLOTS];
  logic                 done_q;
  tag_t                 done_tag_q;
  slot_t                done_slot;
  logic                 fin_any;
  slot_t                fin_slot;
  logic                 lock_q;
  slot_t                lock_slot_q;
  slot_t                rep_slot;

  // Slot sits in the upper tag bits
  assign done_slot = done_tag_q[`TAG_W-1 -: `SLOT_W];

  always_comb begin
    free_slot_o = '0;
    for (int i = `WG_SLOTS - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_slot_o = slot_t'(i);
      end
    end
  end

  always_comb begin
    fin_any  = 1'b0;
    fin_slot = '0;
    for (int i = `WG_SLOTS - 1; i >= 0; i--) begin
      finished[i] = busy_q[i] && (done_cnt_q[i] == wf_cnt_q[i]);
      if (finished[i]) begin
        fin_any  = 1'b1;
        fin_slot = slot_t'(i);
      end
    end
  end

  // Reported slot stays fixed until the arbiter acks it, even if
  // a lower slot finishes in the meantime
  assign rep_slot     = lock_q ? lock_slot_q : fin_slot;
  assign wg_done_o    = lock_q | fin_any;
  assign wg_done_id_o = wg_id_q[rep_slot];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
      done_q <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      done_q <= wf_done_i;
      if (alloc_en_i) begin
        busy_q[free_slot_o] <= 1'b1;
      end
      if (done_ack_i) begin
        busy_q[rep_slot] <= 1'b0;
        lock_q           <= 1'b0;
      end else if (fin_any) begin
        lock_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    done_tag_q <= wf_done_tag_i;
    if (!lock_q) begin
      lock_slot_q <= fin_slot;
    end
    if (alloc_en_i) begin
      wg_id_q[free_slot_o]    <= alloc_wg_id_i;
      wf_cnt_q[free_slot_o]   <= alloc_wf_count_i;
      done_cnt_q[free_slot_o] <= '0;
    end
    // One wavefront retired
    if (done_q) begin
      done_cnt_q[done_slot] <= done_cnt_q[done_slot] + wf_cnt_t'(1);
    end
  end

endmodule

//--- design/gpu_dispatch_cfg.svh
// ****************************************
// GPU dispatch configuration
// Sizes shared by the dispatch RTL and its
// testbench
// ****************************************
`ifndef GPU_DISPATCH_CFG_SVH
`define GPU_DISPATCH_CFG_SVH

// Compute units
`define NUM_CU    4
`define CU_ID_W   2

// Workgroups in flight
`define WG_ID_W   8
`define WG_SLOTS  4
`define SLOT_W    2

// Wavefronts per workgroup, 1 to 8
`define WF_CNT_W  4
`define WF_IDX_W  3

// Tag is {slot, wavefront index}
`define TAG_W     5

// Register file bases
`define VGPR_W    10
`define SGPR_W    8

`endif

//--- design/gpu_dispatch_pkg.sv
// ****************************************
// GPU dispatch shared types
// Field types and FSM state encodings
// ****************************************
`include "gpu_dispatch_cfg.svh"

package gpu_dispatch_pkg;

  typedef logic [`CU_ID_W-1:0]  cu_id_t;
  typedef logic [`WG_ID_W-1:0]  wg_id_t;
  typedef logic [`WF_CNT_W-1:0] wf_cnt_t;
  typedef logic [`SLOT_W-1:0]   slot_t;
  typedef logic [`TAG_W-1:0]    tag_t;
  typedef logic [`VGPR_W-1:0]   vgpr_t;
  typedef logic [`SGPR_W-1:0]   sgpr_t;

  // Workgroup split into wavefronts
  typedef enum logic [1:0] {
    ALLOC_IDLE,
    ALLOC_LOAD,
    ALLOC_PASS
  } alloc_state_e;

  // Done workgroup handed upstream
  typedef enum logic {
    DEALLOC_IDLE,
    DEALLOC_WAIT_ACK
  } dealloc_state_e;

endpackage

//--- design/gpu_dispatch_top.sv
// ****************************************
// GPU workgroup dispatch interface
// Dispatch FSM, per-CU handlers and the
// dealloc arbiter
// ****************************************
`timescale 1ns/1ps
`include "gpu_dispatch_cfg.svh"

module gpu_dispatch_top
  import gpu_dispatch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // Upstream alloc
  input  logic                 alloc_valid_i,
  input  wg_id_t               alloc_wg_id_i,
  input  cu_id_t               alloc_cu_id_i,
  input  wf_cnt_t              alloc_wf_count_i,
  input  vgpr_t                alloc_vgpr_start_i,
  input  sgpr_t                alloc_sgpr_start_i,
  input  vgpr_t                alloc_vgpr_size_i,
  input  sgpr_t                alloc_sgpr_size_i,
  output logic                 alloc_available_o,
  // Wavefronts to CUs
  output logic [`NUM_CU-1:0]   wf_dispatch_o,
  output tag_t                 wf_tag_o,
  output wf_cnt_t              wf_count_o,
  output vgpr_t                wf_vgpr_base_o,
  output sgpr_t                wf_sgpr_base_o,
  // Completions from CUs
  input  logic [`NUM_CU-1:0]   wf_done_i,
  input  tag_t [`NUM_CU-1:0]   wf_done_tag_i,
  // Upstream dealloc
  output logic                 dealloc_valid_o,
  output cu_id_t               dealloc_cu_id_o,
  output wg_id_t               dealloc_wg_id_o,
  input  logic                 dealloc_ack_i
);

  logic [`NUM_CU-1:0]   hdl_alloc_en;
  wg_id_t               hdl_wg_id;
  wf_cnt_t              hdl_wf_count;
  slot_t [`NUM_CU-1:0]  free_slot;
  logic [`NUM_CU-1:0]   wg_done;
  wg_id_t [`NUM_CU-1:0] wg_done_id;
  logic [`NUM_CU-1:0]   done_ack;

  wg_dispatch_fsm wg_dispatch_fsm_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .alloc_valid_i      (alloc_valid_i),
    .alloc_wg_id_i      (alloc_wg_id_i),
    .alloc_cu_id_i      (alloc_cu_id_i),
    .alloc_wf_count_i   (alloc_wf_count_i),
    .alloc_vgpr_start_i (alloc_vgpr_start_i),
    .alloc_vgpr_size_i  (alloc_vgpr_size_i),
    .alloc_sgpr_start_i (alloc_sgpr_start_i),
    .alloc_sgpr_size_i  (alloc_sgpr_size_i),
    .free_slot_i        (free_slot),
    .alloc_available_o  (alloc_available_o),
    .hdl_alloc_en_o     (hdl_alloc_en),
    .hdl_wg_id_o        (hdl_wg_id),
    .hdl_wf_count_o     (hdl_wf_count),
    .wf_dispatch_o      (wf_dispatch_o),
    .wf_tag_o           (wf_tag_o),
    .wf_count_o         (wf_count_o),
    .wf_vgpr_base_o     (wf_vgpr_base_o),
    .wf_sgpr_base_o     (wf_sgpr_base_o)
  );

  // One slot table per CU
  for (genvar i = 0; i < `NUM_CU; i++) begin : g_cu
    cu_handler cu_handler_inst (
      .clk              (clk),
      .rst_n            (rst_n),
      .alloc_en_i       (hdl_alloc_en[i]),
      .alloc_wg_id_i    (hdl_wg_id),
      .alloc_wf_count_i (hdl_wf_count),
      .wf_done_i        (wf_done_i[i]),
      .wf_done_tag_i    (wf_done_tag_i[i]),
      .done_ack_i       (done_ack[i]),
      .free_slot_o      (free_slot[i]),
      .wg_done_o        (wg_done[i]),
      .wg_done_id_o     (wg_done_id[i])
    );
  end

  wg_done_arbiter wg_done_arbiter_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .wg_done_i       (wg_done),
    .wg_done_id_i    (wg_done_id),
    .dealloc_ack_i   (dealloc_ack_i),
    .dealloc_valid_o (dealloc_valid_o),
    .dealloc_cu_id_o (dealloc_cu_id_o),
    .dealloc_wg_id_o (dealloc_wg_id_o),
    .done_ack_o      (done_ack)
  );

endmodule

//--- design/wg_dispatch_fsm.sv
// ****************************************
// Workgroup dispatch FSM
// Takes one allocated workgroup and sends
// its wavefronts to the target CU
// ****************************************
`timescale 1ns/1ps
`include "gpu_dispatch_cfg.svh"

module wg_dispatch_fsm
  import gpu_dispatch_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                alloc_valid_i,
  input  wg_id_t              alloc_wg_id_i,
  input  cu_id_t              alloc_cu_id_i,
  input  wf_cnt_t             alloc_wf_count_i,
  input  vgpr_t               alloc_vgpr_start_i,
  input  vgpr_t               alloc_vgpr_size_i,
  input  sgpr_t               alloc_sgpr_start_i,
  input  sgpr_t               alloc_sgpr_size_i,
  input  slot_t [`NUM_CU-1:0] free_slot_i,
  output logic                alloc_available_o,
  output logic [`NUM_CU-1:0]  hdl_alloc_en_o,
  output wg_id_t              hdl_wg_id_o,
  output wf_cnt_t             hdl_wf_count_o,
  output logic [`NUM_CU-1:0]  wf_dispatch_o,
  output tag_t                wf_tag_o,
  output wf_cnt_t             wf_count_o,
  output vgpr_t               wf_vgpr_base_o,
  output sgpr_t               wf_sgpr_base_o
);

  alloc_state_e          state_q;
  logic                  avail_q;
  logic                  accept;
  logic                  last_wf;
  logic [`NUM_CU-1:0]    cu_onehot;
  logic [`NUM_CU-1:0]    dispatch_q;
  logic [`WF_IDX_W-1:0]  wf_idx_q;
  logic [`WF_IDX_W-1:0]  wf_idx_inc;
  cu_id_t                cu_q;
  wg_id_t                wg_id_q;
  wf_cnt_t               count_q;
  vgpr_t                 vgpr_start_q;
  vgpr_t                 vgpr_size_q;
  sgpr_t                 sgpr_start_q;
  sgpr_t                 sgpr_size_q;
  slot_t                 slot_q;
  tag_t                  tag_q;
  vgpr_t                 vgpr_base_q;
  sgpr_t                 sgpr_base_q;

  assign accept     = (state_q == ALLOC_IDLE) && alloc_valid_i && avail_q;
  assign wf_idx_inc = wf_idx_q + 1'b1;
  // Count goes up to 8, so compare at count width
  assign last_wf    = (wf_cnt_t'(wf_idx_q) + wf_cnt_t'(1)) == count_q;

  always_comb begin
    cu_onehot        = '0;
    cu_onehot[cu_q]  = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ALLOC_IDLE;
      avail_q    <= 1'b0;
      dispatch_q <= '0;
      wf_idx_q   <= '0;
    end else begin
      case (state_q)
        ALLOC_IDLE: begin
          if (accept) begin
            avail_q <= 1'b0;
            state_q <= ALLOC_LOAD;
          end else begin
            avail_q <= 1'b1;
          end
        end
        ALLOC_LOAD: begin
          // First wavefront goes out with the handler write
          dispatch_q <= cu_onehot;
          wf_idx_q   <= '0;
          state_q    <= ALLOC_PASS;
        end
        ALLOC_PASS: begin
          if (last_wf) begin
            dispatch_q <= '0;
            avail_q    <= 1'b1;
            state_q    <= ALLOC_IDLE;
          end else begin
            wf_idx_q <= wf_idx_inc;
          end
        end
        default: begin
          dispatch_q <= '0;
          state_q    <= ALLOC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cu_q         <= alloc_cu_id_i;
      wg_id_q      <= alloc_wg_id_i;
      count_q      <= alloc_wf_count_i;
      vgpr_start_q <= alloc_vgpr_start_i;
      vgpr_size_q  <= alloc_vgpr_size_i;
      sgpr_start_q <= alloc_sgpr_start_i;
      sgpr_size_q  <= alloc_sgpr_size_i;
    end
    if (state_q == ALLOC_LOAD) begin
      slot_q      <= free_slot_i[cu_q];
      tag_q       <= {free_slot_i[cu_q], {`WF_IDX_W{1'b0}}};
      vgpr_base_q <= vgpr_start_q;
      sgpr_base_q <= sgpr_start_q;
    end else if (state_q == ALLOC_PASS && !last_wf) begin
      tag_q       <= {slot_q, wf_idx_inc};
      vgpr_base_q <= vgpr_base_q + vgpr_size_q;
      sgpr_base_q <= sgpr_base_q + sgpr_size_q;
    end
  end

  assign alloc_available_o = avail_q;
  assign hdl_alloc_en_o    = (state_q == ALLOC_LOAD) ? cu_onehot : '0;
  assign hdl_wg_id_o       = wg_id_q;
  assign hdl_wf_count_o    = count_q;
  assign wf_dispatch_o     = dispatch_q;
  assign wf_tag_o          = tag_q;
  assign wf_count_o        = count_q;
  assign wf_vgpr_base_o    = vgpr_base_q;
  assign wf_sgpr_base_o    = sgpr_base_q;

endmodule

//--- design/wg_done_arbiter.sv
// ****************************************
// Done workgroup arbiter
// Fixed priority over CUs, holds dealloc
// request until upstream acks
// ****************************************
`timescale 1ns/1ps
`include "gpu_dispatch_cfg.svh"

module wg_done_arbiter
  import gpu_dispatch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`NUM_CU-1:0]   wg_done_i,
  input  wg_id_t [`NUM_CU-1:0] wg_done_id_i,
  input  logic                 dealloc_ack_i,
  output logic                 dealloc_valid_o,
  output cu_id_t               dealloc_cu_id_o,
  output wg_id_t               dealloc_wg_id_o,
  output logic [`NUM_CU-1:0]   done_ack_o
);

  dealloc_state_e      state_q;
  logic [`NUM_CU-1:0]  req_q;
  logic [`NUM_CU-1:0]  grant;
  logic [`NUM_CU-1:0]  done_ack_q;
  cu_id_t              grant_idx;
  logic                ack_q;
  logic                valid_q;
  cu_id_t              cu_q;
  wg_id_t              wg_q;

  // Lowest set bit wins
  assign grant = req_q & (~req_q + 1'b1);

  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < `NUM_CU; i++) begin
      if (grant[i]) begin
        grant_idx = cu_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= DEALLOC_IDLE;
      req_q      <= '0;
      ack_q      <= 1'b0;
      valid_q    <= 1'b0;
      done_ack_q <= '0;
    end else begin
      req_q <= wg_done_i;
      ack_q <= dealloc_ack_i;
      case (state_q)
        DEALLOC_IDLE: begin
          if (|grant) begin
            valid_q    <= 1'b1;
            done_ack_q <= grant;
            state_q    <= DEALLOC_WAIT_ACK;
          end
        end
        DEALLOC_WAIT_ACK: begin
          done_ack_q <= '0;
          if (ack_q) begin
            valid_q <= 1'b0;
            state_q <= DEALLOC_IDLE;
          end
        end
        default: begin
          valid_q    <= 1'b0;
          done_ack_q <= '0;
          state_q    <= DEALLOC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == DEALLOC_IDLE && |grant) begin
      cu_q <= grant_idx;
      wg_q <= wg_done_id_i[grant_idx];
    end
  end

  assign dealloc_valid_o = valid_q;
  assign dealloc_cu_id_o = cu_q;
  assign dealloc_wg_id_o = wg_q;
  assign done_ack_o      = done_ack_q;

endmodule

//--- flist.f
+incdir+design
design/gpu_dispatch_pkg.sv
design/wg_dispatch_fsm.sv
design/cu_handler.sv
design/wg_done_arbiter.sv
design/gpu_dispatch_top.sv
bench/gpu_dispatch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module gpu_dispatch_tb \
  -o gpu_dispatch_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/gpu_dispatch_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "NO ERRORS" sim.log; then
  exit 0
fi
exit 1
